/* spw_char_pkg.sv */
`default_nettype none

package spw_char_pkg;

	// **********************************************************************
	// character fields
	// **********************************************************************

	typedef logic [8:0] n_char_t;		// bit 8 is the control flag.

	typedef logic [7:0] time_code_t;

	typedef logic [13:0] bit_sel_t;		// one-hot, bit 0 parity, bit 1 flag.

	typedef enum logic [1:0]
	{
		null_c,
		fct_c,
		time_c,
		data_c
	} char_kind_t;

	// **********************************************************************
	// control codes, flag in bit 2, sent msb first
	// **********************************************************************

	localparam logic [2:0] esc_code = 3'b111;
	localparam logic [2:0] fct_code = 3'b100;
	localparam logic [2:0] eop_code = 3'b101;
	localparam logic [2:0] eep_code = 3'b110;

	// **********************************************************************
	// character lengths in bits
	// **********************************************************************

	localparam int data_len = 10;
	localparam int eop_len  = 4;
	localparam int fct_len  = 4;
	localparam int null_len = 8;		// esc then fct.
	localparam int time_len = 14;		// esc then data char.

endpackage

`default_nettype wire

/* spw_tx_pkg.sv */
`default_nettype none

package spw_tx_pkg;

	// **********************************************************************
	// sequencer state
	// **********************************************************************

	typedef enum logic
	{
		st_idle,
		st_char
	} seq_state_t;

	// **********************************************************************
	// transfers between the transmitter blocks
	// **********************************************************************

	// character in flight and the bit on the line this cycle.
	typedef struct packed
	{
		spw_char_pkg::char_kind_t kind;
		spw_char_pkg::n_char_t    n_char;
		spw_char_pkg::time_code_t time_code;
		spw_char_pkg::bit_sel_t   bit_sel;	// all zero when no bit is sent.
	} char_req_t;

	// one encoded bit.
	typedef struct packed
	{
		logic value;
		logic last;		// final bit of the character.
	} enc_bit_t;

endpackage

`default_nettype wire

/* spw_tx_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module spw_tx_sequencer
(
	input  logic                     pclk_tx,
	input  logic                     rst,
	input  logic                     enable,
	input  logic                     tx_write,
	input  spw_char_pkg::n_char_t    tx_data,
	output logic                     tx_ready,
	input  logic                     fct_req,
	input  logic                     tick_in,
	input  spw_char_pkg::time_code_t time_in,
	input  logic                     char_done,
	output spw_tx_pkg::char_req_t    char_req
);

	spw_tx_pkg::seq_state_t   state;
	spw_tx_pkg::char_req_t    next_req;
	spw_char_pkg::n_char_t    buf_q;
	spw_char_pkg::time_code_t time_q;
	logic                     buf_full;
	logic                     buf_full_nxt;
	logic                     buf_take;
	logic                     buf_free;
	logic                     data_busy;
	logic                     fct_pend;
	logic                     tick_pend;
	logic                     load;

	// buffered n-char on the line right now.
	assign data_busy = (char_req.kind == spw_char_pkg::data_c) && (char_req.bit_sel != '0);

	assign buf_take     = tx_write && tx_ready;
	assign buf_free     = char_done && data_busy;	// freed after its last bit.
	assign buf_full_nxt = buf_take || (buf_full && !buf_free);
	assign load         = (state == spw_tx_pkg::st_char) && char_done;

	// **********************************************************************
	// next character by priority
	// **********************************************************************

	always_comb
	begin
		next_req           = char_req;
		next_req.n_char    = buf_q;
		next_req.time_code = time_q;
		next_req.bit_sel   = spw_char_pkg::bit_sel_t'(1);
		if (tick_pend)
			next_req.kind = spw_char_pkg::time_c;
		else if (fct_pend)
			next_req.kind = spw_char_pkg::fct_c;
		else if (buf_full && !data_busy)
			next_req.kind = spw_char_pkg::data_c;
		else
			next_req.kind = spw_char_pkg::null_c;
	end

	// **********************************************************************
	// n-char buffer and pending requests
	// **********************************************************************

	always_ff @(posedge pclk_tx)
	begin
		if (buf_take)
			buf_q <= tx_data;
		if (tick_in)
			time_q <= time_in;		// a later tick replaces the value.
	end

	always_ff @(posedge pclk_tx)
	begin
		if (rst)
		begin
			buf_full  <= 1'b0;
			tx_ready  <= 1'b0;
			fct_pend  <= 1'b0;
			tick_pend <= 1'b0;
		end
		else
		begin
			buf_full <= buf_full_nxt;
			tx_ready <= !buf_full_nxt;
			if (load && (next_req.kind == spw_char_pkg::fct_c))
				fct_pend <= 1'b0;	// a request arriving now merges.
			else if (fct_req)
				fct_pend <= 1'b1;
			if (tick_in)
				tick_pend <= 1'b1;
			else if (load && (next_req.kind == spw_char_pkg::time_c))
				tick_pend <= 1'b0;
		end
	end

	// **********************************************************************
	// state and bit counter
	// **********************************************************************

	always_ff @(posedge pclk_tx)
	begin
		if (rst)
		begin
			state    <= spw_tx_pkg::st_idle;
			char_req <= '{kind: spw_char_pkg::null_c, n_char: '0, time_code: '0, bit_sel: '0};
		end
		else
		begin
			case (state)
				spw_tx_pkg::st_idle:
				begin
					if (enable)
					begin
						state         <= spw_tx_pkg::st_char;
						char_req.kind <= spw_char_pkg::data_c;	// empty slot ends at once.
					end
				end
				spw_tx_pkg::st_char:
				begin
					if (load)
						char_req <= next_req;
					else
						char_req.bit_sel <= char_req.bit_sel << 1;
				end
				default:
				begin
					state <= spw_tx_pkg::st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* spw_data_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module spw_data_encoder
(
	input  spw_tx_pkg::char_req_t char_req,
	input  logic                  parity_seed,
	output spw_tx_pkg::enc_bit_t  enc_bit
);

	logic                   flag;
	logic [2:0]             end_code;
	spw_char_pkg::bit_sel_t pattern;
	spw_char_pkg::bit_sel_t last_pos;

	assign flag = char_req.n_char[8];

	// eop on 0, eep on 1.
	assign end_code = (char_req.n_char[1:0] == 2'd1) ? spw_char_pkg::eep_code :
		spw_char_pkg::eop_code;

	// **********************************************************************
	// bit pattern indexed by bit position
	// **********************************************************************

	always_comb
	begin
		pattern    = '0;
		pattern[0] = ~(parity_seed ^ flag);	// odd parity.
		pattern[1] = flag;
		if (flag)
		begin
			pattern[2] = end_code[1];
			pattern[3] = end_code[0];
			last_pos   = spw_char_pkg::bit_sel_t'(1) << (spw_char_pkg::eop_len - 1);
		end
		else
		begin
			pattern[spw_char_pkg::data_len-1:2] = char_req.n_char[7:0];	// lsb first.
			last_pos = spw_char_pkg::bit_sel_t'(1) << (spw_char_pkg::data_len - 1);
		end
	end

	// **********************************************************************
	// selected bit
	// **********************************************************************

	always_comb
	begin
		enc_bit.value = |(pattern & char_req.bit_sel);
		if (char_req.bit_sel == '0)
			enc_bit.last = 1'b1;	// start slot, no bit sent.
		else
			enc_bit.last = |(last_pos & char_req.bit_sel);
	end

endmodule

`default_nettype wire

/* spw_ctrl_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module spw_ctrl_encoder
(
	input  spw_tx_pkg::char_req_t char_req,
	input  logic                  parity_seed,
	output spw_tx_pkg::enc_bit_t  enc_bit
);

	logic [2:0]             lead_code;
	spw_char_pkg::bit_sel_t pattern;
	spw_char_pkg::bit_sel_t last_pos;

	// fct alone, otherwise esc leads.
	assign lead_code = (char_req.kind == spw_char_pkg::fct_c) ? spw_char_pkg::fct_code :
		spw_char_pkg::esc_code;

	// **********************************************************************
	// bit pattern indexed by bit position
	// **********************************************************************

	always_comb
	begin
		pattern    = '0;
		last_pos   = '0;
		pattern[0] = ~(parity_seed ^ lead_code[2]);
		pattern[1] = lead_code[2];
		pattern[2] = lead_code[1];
		pattern[3] = lead_code[0];
		case (char_req.kind)
			spw_char_pkg::fct_c:
			begin
				last_pos = spw_char_pkg::bit_sel_t'(1) << (spw_char_pkg::fct_len - 1);
			end
			spw_char_pkg::null_c:
			begin
				// second parity covers the esc bits.
				pattern[4] = ~(spw_char_pkg::esc_code[1] ^ spw_char_pkg::esc_code[0] ^
					spw_char_pkg::fct_code[2]);
				pattern[5] = spw_char_pkg::fct_code[2];
				pattern[6] = spw_char_pkg::fct_code[1];
				pattern[7] = spw_char_pkg::fct_code[0];
				last_pos   = spw_char_pkg::bit_sel_t'(1) << (spw_char_pkg::null_len - 1);
			end
			spw_char_pkg::time_c:
			begin
				pattern[4]    = ~(spw_char_pkg::esc_code[1] ^ spw_char_pkg::esc_code[0]);
				pattern[5]    = 1'b0;			// data flag.
				pattern[13:6] = char_req.time_code;	// lsb first.
				last_pos      = spw_char_pkg::bit_sel_t'(1) << (spw_char_pkg::time_len - 1);
			end
			default:
			begin
				pattern = '0;	// data chars go through the other encoder.
			end
		endcase
	end

	assign enc_bit.value = |(pattern & char_req.bit_sel);
	assign enc_bit.last  = |(last_pos & char_req.bit_sel);

endmodule

`default_nettype wire

/* spw_ds_line_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module spw_ds_line_driver
(
	input  logic                     pclk_tx,
	input  logic                     rst,
	input  spw_char_pkg::char_kind_t kind,
	input  spw_tx_pkg::enc_bit_t     data_bit,
	input  spw_tx_pkg::enc_bit_t     ctrl_bit,
	output logic                     parity_seed,
	output logic                     char_done,
	output logic                     d,
	output logic                     s
);

	spw_tx_pkg::enc_bit_t                      sel;
	logic [$clog2(spw_char_pkg::time_len)-1:0] pos;
	logic                                      two_part;
	logic                                      is_parity;
	logic                                      is_flag;
	logic                                      live;
	logic                                      acc;

	assign sel       = (kind == spw_char_pkg::data_c) ? data_bit : ctrl_bit;
	assign char_done = sel.last;
	assign two_part  = (kind == spw_char_pkg::null_c) || (kind == spw_char_pkg::time_c);

	// inner char of null and time-code starts at bit 4.
	assign is_parity = (pos == 'd0) || (two_part && (pos == 'd4));
	assign is_flag   = (pos == 'd1) || (two_part && (pos == 'd5));

	assign parity_seed = acc;

	always_ff @(posedge pclk_tx)
	begin
		if (rst)
		begin
			d    <= 1'b0;
			s    <= 1'b0;
			live <= 1'b0;
			pos  <= '0;
			acc  <= 1'b0;
		end
		else
		begin
			if (char_done)
				live <= 1'b1;		// first boundary out of idle.
			pos <= char_done ? '0 : pos + 1'b1;
			if (live)
			begin
				d <= sel.value;
				if (sel.value == d)
					s <= ~s;	// strobe toggles when d holds.
				if (is_flag)
					acc <= 1'b0;
				else if (!is_parity)
					acc <= acc ^ sel.value;
			end
		end
	end

endmodule

`default_nettype wire

/* spw_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spw_tx_top
(
	input  logic                     pclk_tx,
	input  logic                     rst,
	input  logic                     enable,
	input  logic                     tx_write,
	input  spw_char_pkg::n_char_t    tx_data,
	output logic                     tx_ready,
	input  logic                     fct_req,
	input  logic                     tick_in,
	input  spw_char_pkg::time_code_t time_in,
	output logic                     d,
	output logic                     s
);

	spw_tx_pkg::char_req_t char_req;
	spw_tx_pkg::enc_bit_t  data_bit;
	spw_tx_pkg::enc_bit_t  ctrl_bit;
	logic                  parity_seed;
	logic                  char_done;

	spw_tx_sequencer seq_i
	(
		.pclk_tx   (pclk_tx),
		.rst       (rst),
		.enable    (enable),
		.tx_write  (tx_write),
		.tx_data   (tx_data),
		.tx_ready  (tx_ready),
		.fct_req   (fct_req),
		.tick_in   (tick_in),
		.time_in   (time_in),
		.char_done (char_done),
		.char_req  (char_req)
	);

	spw_data_encoder data_enc_i
	(
		.char_req    (char_req),
		.parity_seed (parity_seed),
		.enc_bit     (data_bit)
	);

	spw_ctrl_encoder ctrl_enc_i
	(
		.char_req    (char_req),
		.parity_seed (parity_seed),
		.enc_bit     (ctrl_bit)
	);

	spw_ds_line_driver line_i
	(
		.pclk_tx     (pclk_tx),
		.rst         (rst),
		.kind        (char_req.kind),
		.data_bit    (data_bit),
		.ctrl_bit    (ctrl_bit),
		.parity_seed (parity_seed),
		.char_done   (char_done),
		.d           (d),
		.s           (s)
	);

endmodule

`default_nettype wire

/* tb_spw_tx_tasks.svh */
// **********************************************************************
// failure reporting and typed compares
// **********************************************************************

task automatic abort_run(input string msg);
	$display("%s", msg);
	$display("Some tests failed");
	$fatal(1);
endtask

task automatic check_kind(input string name, input spw_char_pkg::char_kind_t exp,
	input spw_char_pkg::char_kind_t act);
	if (act !== exp)
		abort_run($sformatf("** Error: %s expected %s actual %s", name, exp.name(), act.name()));
endtask

task automatic check_n_char(input string name, input spw_char_pkg::n_char_t exp,
	input spw_char_pkg::n_char_t act);
	if (act !== exp)
		abort_run($sformatf("** Error: %s expected %03h actual %03h", name, exp, act));
endtask

task automatic check_time(input string name, input spw_char_pkg::time_code_t exp,
	input spw_char_pkg::time_code_t act);
	if (act !== exp)
		abort_run($sformatf("** Error: %s expected %02h actual %02h", name, exp, act));
endtask

// **********************************************************************
// stimulus and decoded character helpers
// **********************************************************************

task automatic drive_strobes(input logic write, input spw_char_pkg::n_char_t data,
	input logic fct, input logic tick, input spw_char_pkg::time_code_t t);
	@(negedge pclk_tx);
	while (write && (tx_ready !== 1'b1))
		@(negedge pclk_tx);
	tx_write = write;
	tx_data = data;
	fct_req = fct;
	tick_in = tick;
	time_in = t;
	@(negedge pclk_tx);
	tx_write = 1'b0;
	fct_req = 1'b0;
	tick_in = 1'b0;
	if (write && (tx_ready !== 1'b0))
		abort_run("tx_ready did not fall after an accepted write");
endtask

task automatic next_char(output rx_char_t c);
	while (rx_q.size() == 0)
		@(negedge pclk_tx);
	c = rx_q.pop_front();
endtask

// skips the nulls sent while idle.
task automatic expect_char(input string name, input spw_char_pkg::char_kind_t kind,
	input spw_char_pkg::n_char_t v);
	rx_char_t c;
	next_char(c);
	while (c.kind == spw_char_pkg::null_c)
		next_char(c);
	check_kind(name, kind, c.kind);
	if (kind == spw_char_pkg::data_c)
		check_n_char(name, v, c.n_char);
	else if (kind == spw_char_pkg::time_c)
		check_time(name, v[7:0], c.n_char[7:0]);
endtask

function automatic spw_char_pkg::n_char_t rand_data();
	return {1'b0, 8'($urandom)};
endfunction

// **********************************************************************
// directed tests
// **********************************************************************

task automatic test_null_idle();
	rx_char_t c;
	repeat (20)
	begin
		@(negedge pclk_tx);
		if ((d !== 1'b0) || (s !== 1'b0))
			abort_run("d or s moved before enable was raised");
	end
	enable = 1'b1;
	repeat (3)
	begin
		next_char(c);
		check_kind("null_idle", spw_char_pkg::null_c, c.kind);
	end
endtask

task automatic test_data_stream();
	spw_char_pkg::n_char_t exp_q[$];
	spw_char_pkg::n_char_t v;
	int                    i;
	for (i = 0; i < n_rand; i++)
	begin
		v = rand_data();
		exp_q.push_back(v);
		drive_strobes(1'b1, v, 1'b0, 1'b0, '0);
	end
	while (exp_q.size() != 0)
		expect_char("data_stream", spw_char_pkg::data_c, exp_q.pop_front());
endtask

task automatic test_eop_eep();
	spw_char_pkg::n_char_t v;
	v = rand_data();
	drive_strobes(1'b1, v, 1'b0, 1'b0, '0);
	drive_strobes(1'b1, 9'h100, 1'b0, 1'b0, '0);
	drive_strobes(1'b1, 9'h101, 1'b0, 1'b0, '0);
	expect_char("eop_eep", spw_char_pkg::data_c, v);
	expect_char("eop_eep", spw_char_pkg::data_c, 9'h100);
	expect_char("eop_eep", spw_char_pkg::data_c, 9'h101);
endtask

task automatic test_fct_priority();
	spw_char_pkg::n_char_t v;
	v = rand_data();
	drive_strobes(1'b1, v, 1'b1, 1'b0, '0);
	expect_char("fct_priority", spw_char_pkg::fct_c, '0);
	expect_char("fct_priority", spw_char_pkg::data_c, v);
endtask

task automatic test_time_code();
	spw_char_pkg::n_char_t    v;
	spw_char_pkg::time_code_t t;
	v = rand_data();
	t = spw_char_pkg::time_code_t'($urandom);
	drive_strobes(1'b1, v, 1'b1, 1'b1, t);
	expect_char("time_code", spw_char_pkg::time_c, {1'b0, t});
	expect_char("time_code", spw_char_pkg::fct_c, '0);
	expect_char("time_code", spw_char_pkg::data_c, v);
endtask

task automatic test_back_pressure();
	spw_char_pkg::n_char_t v;
	rx_char_t              c;
	v = rand_data();
	drive_strobes(1'b1, v, 1'b0, 1'b0, '0);
	tx_write = 1'b1;	// buffer full, must be dropped.
	tx_data = {1'b0, ~v[7:0]};
	@(negedge pclk_tx);
	tx_write = 1'b0;
	expect_char("back_pressure", spw_char_pkg::data_c, v);
	repeat (2)
	begin
		next_char(c);
		check_kind("back_pressure", spw_char_pkg::null_c, c.kind);
	end
endtask

/* tb_spw_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spw_tx;

	typedef struct packed
	{
		spw_char_pkg::char_kind_t kind;
		spw_char_pkg::n_char_t    n_char;	// time value in bits 7:0.
	} rx_char_t;

	localparam int n_rand = 4;
	localparam int test_bits = 5 * spw_char_pkg::null_len +
		(n_rand + 4) * spw_char_pkg::data_len + 2 * spw_char_pkg::eop_len +
		2 * spw_char_pkg::fct_len + spw_char_pkg::time_len;
	localparam int watchdog_cycles = 20 * test_bits + 1000;

	logic                     pclk_tx;
	logic                     rst;
	logic                     enable;
	logic                     tx_write;
	spw_char_pkg::n_char_t    tx_data;
	logic                     tx_ready;
	logic                     fct_req;
	logic                     tick_in;
	spw_char_pkg::time_code_t time_in;
	logic                     d;
	logic                     s;
	rx_char_t                 rx_q[$];
	logic                     line_ds;
	logic                     seed;
	int unsigned              seed_dummy;

	`include "tb_spw_tx_tasks.svh"

	spw_tx_top dut_i
	(
		.pclk_tx  (pclk_tx),
		.rst      (rst),
		.enable   (enable),
		.tx_write (tx_write),
		.tx_data  (tx_data),
		.tx_ready (tx_ready),
		.fct_req  (fct_req),
		.tick_in  (tick_in),
		.time_in  (time_in),
		.d        (d),
		.s        (s)
	);

	initial
	begin
		pclk_tx = 1'b0;
		forever #5 pclk_tx = ~pclk_tx;
	end

	// **********************************************************************
	// ds decoder
	// **********************************************************************

	task automatic get_bit(output logic b);
		@(negedge pclk_tx);
		while ((d ^ s) == line_ds)
			@(negedge pclk_tx);
		line_ds = d ^ s;
		b = d;
	endtask

	task automatic get_raw(output logic flag, output logic [7:0] bits);
		logic p;
		logic b;
		int   n;
		int   i;
		get_bit(p);
		get_bit(flag);
		if (p !== ~(seed ^ flag))
			abort_run("parity error on the line");
		seed = 1'b0;		// covers the bits after this flag.
		bits = '0;
		n = flag ? 2 : 8;
		for (i = 0; i < n; i++)
		begin
			get_bit(b);
			seed = seed ^ b;
			bits[i] = b;	// lsb first.
		end
	endtask

	task automatic push_rx(input spw_char_pkg::char_kind_t kind,
		input spw_char_pkg::n_char_t v);
		rx_char_t c;
		c.kind = kind;
		c.n_char = v;
		rx_q.push_back(c);
	endtask

	task automatic decode_char();
		logic       flag;
		logic [7:0] v;
		logic [2:0] code;
		get_raw(flag, v);
		code = {1'b1, v[0], v[1]};
		if (!flag)
			push_rx(spw_char_pkg::data_c, {1'b0, v});
		else if (code == spw_char_pkg::fct_code)
			push_rx(spw_char_pkg::fct_c, '0);
		else if (code == spw_char_pkg::eop_code)
			push_rx(spw_char_pkg::data_c, 9'h100);
		else if (code == spw_char_pkg::eep_code)
			push_rx(spw_char_pkg::data_c, 9'h101);
		else
		begin
			// after esc the next char tells null from time-code.
			get_raw(flag, v);
			code = {1'b1, v[0], v[1]};
			if (!flag)
				push_rx(spw_char_pkg::time_c, {1'b0, v});
			else if (code == spw_char_pkg::fct_code)
				push_rx(spw_char_pkg::null_c, '0);
			else
				abort_run("escape followed by a character other than fct or data");
		end
	endtask

	initial
	begin
		line_ds = 1'b0;
		seed = 1'b0;
		@(negedge rst);
		forever
			decode_char();
	end

	// **********************************************************************
	// watchdog and test sequence
	// **********************************************************************

	initial
	begin
		repeat (watchdog_cycles) @(posedge pclk_tx);
		abort_run("timeout, the tests did not finish in time");
	end

	initial
	begin
		seed_dummy = $urandom(32'h0700adb7);
		rst = 1'b1;
		enable = 1'b0;
		tx_write = 1'b0;
		tx_data = '0;
		fct_req = 1'b0;
		tick_in = 1'b0;
		time_in = '0;
		repeat (10) @(posedge pclk_tx);
		@(negedge pclk_tx);
		rst = 1'b0;
		test_null_idle();
		test_data_stream();
		test_eop_eep();
		test_fct_priority();
		test_time_code();
		test_back_pressure();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
spw_char_pkg.sv
spw_tx_pkg.sv
spw_tx_sequencer.sv
spw_data_encoder.sv
spw_ctrl_encoder.sv
spw_ds_line_driver.sv
spw_tx_top.sv
tb_spw_tx.sv
